// File: Makefile
# Store buffer simulation with Verilator

VERILATOR ?= verilator
TOP       ?= sb_tb
FILELIST  ?= sb_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sb_cfg.svh
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// Store buffer sizing

// log2 of the entry count, sets pointer width
`define SB_LOG 2

// Number of buffered stores
`define SB_ENTRIES 4

// Keep SB_ENTRIES equal to 2**SB_LOG

`endif

// File: sb_ctrl.sv
`timescale 1ns/1ps

module sb_ctrl (
	input  logic                clk_i,
	input  logic                rst_i,
	input  sb_pkg::sb_cpu_req_t cpu_req_i,
	output logic                cpu_ack_o,	// One cycle pulse
	output logic [31:0]         cpu_rdat_o,	// Valid with load ack
	output logic                fifo_wr_o,
	output sb_pkg::sb_entry_t   fifo_dat_o,
	input  logic                fifo_full_i,
	input  logic                fifo_empty_i,
	input  logic                drain_busy_i,
	input  sb_pkg::sb_bus_req_t drain_req_i,
	output logic                drain_ack_o,
	output sb_pkg::sb_bus_req_t bus_req_o,
	input  logic                bus_ack_i,
	input  logic [31:0]         bus_rdat_i
);

	logic                store_req;
	logic                load_req;
	logic                load_start;
	logic                load_act;	// Load owns the bus
	logic                load_done;
	sb_pkg::sb_bus_req_t load_bus;

	// Ack cycle masks the still held request
	assign store_req = cpu_req_i.stb && cpu_req_i.we && !cpu_ack_o;
	assign load_req = cpu_req_i.stb && !cpu_req_i.we && !cpu_ack_o;

	assign fifo_wr_o = store_req && !fifo_full_i;	// Waits while full

	// Load only after every older store has left
	assign load_start = load_req && !load_act && fifo_empty_i && !drain_busy_i;
	assign load_done = load_act && bus_ack_i;

	// Store entry straight from the request
	always_comb begin
		fifo_dat_o.addr = cpu_req_i.addr;
		fifo_dat_o.data = cpu_req_i.data;
		fifo_dat_o.sel = cpu_req_i.sel;
	end

	// Read cycle built from the held CPU request
	always_comb begin
		load_bus.cyc = 1'b1;
		load_bus.we = 1'b0;
		load_bus.addr = cpu_req_i.addr;
		load_bus.data = '0;	// Unused on reads
		load_bus.sel = cpu_req_i.sel;
	end

	// Bus mux, drain gets it unless a load is running
	assign bus_req_o = load_act ? load_bus : drain_req_i;
	assign drain_ack_o = bus_ack_i && !load_act;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cpu_ack_o <= 1'b0;
			load_act <= 1'b0;
		end else begin
			cpu_ack_o <= fifo_wr_o || load_done;	// Store push or load return
			if (load_start)
				load_act <= 1'b1;
			else if (load_done)
				load_act <= 1'b0;	// cyc drops next cycle
		end
	end

	// Read data capture
	always_ff @(posedge clk_i) begin
		if (load_done)
			cpu_rdat_o <= bus_rdat_i;
	end

endmodule

// File: sb_drain.sv
`timescale 1ns/1ps

module sb_drain (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                fifo_empty_i,
	input  sb_pkg::sb_entry_t   fifo_dat_i,	// FIFO output register
	output logic                fifo_rd_o,	// Pop strobe
	output sb_pkg::sb_bus_req_t wr_req_o,	// Write offered to the bus
	input  logic                wr_ack_i,
	output logic                busy_o	// Entry in flight
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t state;
	state_t state_nxt;

	// Pop only from idle with data waiting
	assign fifo_rd_o = (state == ST_IDLE) && !fifo_empty_i;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (fifo_rd_o)
					state_nxt = ST_BUSY;	// Entry lands in FIFO dat_o at this edge
			end
			ST_BUSY: begin
				if (wr_ack_i)
					state_nxt = ST_IDLE;	// Free to pop next cycle
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	// FIFO output register holds the popped entry
	// No other pop while busy, so it stays put until the ack
	always_comb begin
		wr_req_o.cyc = (state == ST_BUSY);
		wr_req_o.we = 1'b1;	// Always a write
		wr_req_o.addr = fifo_dat_i.addr;
		wr_req_o.data = fifo_dat_i.data;
		wr_req_o.sel = fifo_dat_i.sel;
	end

	assign busy_o = (state == ST_BUSY);

endmodule

// File: sb_fifo.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_fifo #(
	parameter type T = sb_pkg::sb_entry_t,	// Payload type
	parameter int LOG = `SB_LOG,	// Pointer width
	parameter int ENTRIES = `SB_ENTRIES	// Depth
) (
	input  logic clk_i,
	input  logic rst_i,
	input  T     dat_i,	// Write data
	input  logic wr_i,	// Push strobe
	input  logic rd_i,	// Pop strobe
	output T     dat_o,	// Registered head, updated on pop
	output logic full_o,
	output logic empty_o
);

	// Pointer and count limits
	localparam logic [LOG-1:0] PTR_LAST = LOG'(ENTRIES - 1);
	localparam logic [LOG:0] CNT_ALMOST = (LOG+1)'(ENTRIES - 1);
	localparam logic [LOG:0] CNT_ONE = (LOG+1)'(1);

	T mem [ENTRIES];	// Entry storage

	logic [LOG-1:0] wr_ptr;
	logic [LOG-1:0] rd_ptr;
	logic [LOG-1:0] wr_ptr_nxt;
	logic [LOG-1:0] rd_ptr_nxt;
	logic [LOG:0]   cnt;	// Occupancy 0..ENTRIES
	logic           push_pop;
	logic           push_only;
	logic           pop_only;

	// Wrapping pointer increments
	assign wr_ptr_nxt = (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
	assign rd_ptr_nxt = (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;

	// Both strobes win over the flags
	assign push_pop = wr_i && rd_i;
	assign push_only = wr_i && !rd_i && !full_o;	// Dropped when full
	assign pop_only = rd_i && !wr_i && !empty_o;	// Dropped when empty

	// Storage write
	always_ff @(posedge clk_i) begin
		if (push_pop || push_only)
			mem[wr_ptr] <= dat_i;
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
			full_o <= 1'b0;
			empty_o <= 1'b1;
			dat_o <= '0;
		end else if (push_pop) begin
			// Count unchanged
			wr_ptr <= wr_ptr_nxt;
			rd_ptr <= rd_ptr_nxt;
			if (empty_o)
				dat_o <= dat_i;	// Straight through
			else
				dat_o <= mem[rd_ptr];
		end else if (push_only) begin
			wr_ptr <= wr_ptr_nxt;
			cnt <= cnt + 1'b1;
			empty_o <= 1'b0;
			if (cnt == CNT_ALMOST)
				full_o <= 1'b1;	// Last slot taken
		end else if (pop_only) begin
			rd_ptr <= rd_ptr_nxt;
			cnt <= cnt - 1'b1;
			full_o <= 1'b0;
			dat_o <= mem[rd_ptr];	// Head moves to output reg
			if (cnt == CNT_ONE)
				empty_o <= 1'b1;
		end
	end

endmodule

// File: sb_pkg.sv
package sb_pkg;

	// CPU data port request, held until ack
	typedef struct packed {
		logic        stb;	// Request strobe
		logic        we;	// Store when set, load otherwise
		logic [31:0] addr;	// Byte address
		logic [31:0] data;	// Store data
		logic [3:0]  sel;	// Byte enables
	} sb_cpu_req_t;

	// One buffered store
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  sel;	// Byte lanes to write
	} sb_entry_t;

	// Memory bus request
	// cyc stays high until the bus acks
	typedef struct packed {
		logic        cyc;	// Bus cycle active
		logic        we;	// Write cycle
		logic [31:0] addr;
		logic [31:0] data;	// Write data, don't care on reads
		logic [3:0]  sel;
	} sb_bus_req_t;

	// Widths as seen on the ports
	// cpu req 70, entry 68, bus req 70

endpackage

// File: sb_tb.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_tb;

	localparam logic [31:0] BASE = 32'h0000_1000;	// Memory window start
	localparam int ACK_LIMIT = 400;	// Cycles per CPU request
	localparam int DRAIN_LIMIT = 3000;	// Cycles to empty the buffer

	logic                clk;
	logic                rst;
	sb_pkg::sb_cpu_req_t cpu_req;
	logic                cpu_ack;
	logic [31:0]         cpu_rdat;
	sb_pkg::sb_bus_req_t bus_req;
	logic                bus_ack;
	logic [31:0]         bus_rdat;
	logic                slow;	// Long memory ack delays
	logic                wr_stb;
	sb_pkg::sb_entry_t   wr_ent;

	logic [31:0]       lfsr_q = 32'h7a78_0db5;
	logic [31:0]       model [logic [31:0]];	// Word address to data, sparse
	sb_pkg::sb_entry_t exp_q [$];	// Stores not yet seen on the bus
	int                errors = 0;
	int                tests_run = 0;
	int                tests_failed = 0;

	tb_clkgen clk_gen_i (
		.clk_o (clk),
		.rst_o (rst)
	);

	sb_tb_mem #(.BASE(BASE)) mem_i (
		.clk_i      (clk),
		.rst_i      (rst),
		.slow_i     (slow),
		.bus_req_i  (bus_req),
		.bus_ack_o  (bus_ack),
		.bus_rdat_o (bus_rdat),
		.wr_stb_o   (wr_stb),
		.wr_ent_o   (wr_ent)
	);

	sb_top dut_i (
		.clk_i      (clk),
		.rst_i      (rst),
		.cpu_req_i  (cpu_req),
		.cpu_ack_o  (cpu_ack),
		.cpu_rdat_o (cpu_rdat),
		.bus_req_o  (bus_req),
		.bus_ack_i  (bus_ack),
		.bus_rdat_i (bus_rdat)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};	// One step per bit
		end
		return r;
	endfunction

	function automatic logic [31:0] rand_addr(input int idx_bits);
		logic [31:0] r;
		r = rand_bits(idx_bits);
		return BASE + (r << 2);	// Word aligned
	endfunction

	function automatic logic [3:0] rand_sel();
		logic [31:0] r;
		r = rand_bits(4);
		return r[3:0];
	endfunction

	// Power-up contents of the bus memory
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a ^ 32'h5a5a_a5a5) + {a[15:0], a[31:16]};
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		if (model.exists(key))
			return model[key];
		return fill_word(key);
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] sel);
		logic [31:0] w;
		w = model_read(addr);
		for (int b = 0; b < 4; b++)
			if (sel[b])
				w[b*8 +: 8] = data[b*8 +: 8];	// Byte lane merge
		model[{addr[31:2], 2'b00}] = w;
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic wait_ack(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!cpu_ack)
			report_failure({"timeout waiting for the acknowledge of a ", what});
	endtask

	task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] sel);
		sb_pkg::sb_entry_t e;
		e.addr = addr;
		e.data = data;
		e.sel = sel;
		exp_q.push_back(e);	// Expected bus order is issue order
		model_write(addr, data, sel);
		cpu_req.stb = 1'b1;
		cpu_req.we = 1'b1;
		cpu_req.addr = addr;
		cpu_req.data = data;
		cpu_req.sel = sel;
		wait_ack("store");
		cpu_req.stb = 1'b0;	// Next request may follow right away
	endtask

	task automatic do_load(input logic [31:0] addr);
		cpu_req.stb = 1'b1;
		cpu_req.we = 1'b0;
		cpu_req.addr = addr;
		cpu_req.data = '0;
		cpu_req.sel = 4'hf;
		wait_ack("load");
		if (cpu_ack)
			check_val("cpu_rdat_o", cpu_rdat, model_read(addr));	// Valid with the ack
		cpu_req.stb = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
			report_failure("buffered stores never reached the bus");
	endtask

	task automatic compare_memory();
		logic [31:0] a;
		for (int i = 0; i < 16; i++) begin
			a = BASE + 32'(i) * 32'd4;
			check_val($sformatf("mem[%0d]", i), mem_i.mem[i], model_read(a));
		end
	endtask

	// Every bus write must be the oldest outstanding store
	always @(posedge clk) begin : write_monitor
		sb_pkg::sb_entry_t e;
		if (wr_stb) begin
			if (exp_q.size() == 0) begin
				report_failure("bus write seen with no store outstanding");
			end else begin
				e = exp_q.pop_front();
				check_val("bus addr", wr_ent.addr, e.addr);
				check_val("bus data", wr_ent.data, e.data);
				check_val("bus sel", 32'(wr_ent.sel), 32'(e.sel));
			end
		end
	end

	initial begin : main_seq
		int          n;
		int          err0;
		logic [31:0] r;
		cpu_req = '0;
		slow = 1'b0;

		// Reset, outputs quiet during and after
		err0 = errors;
		n = 0;
		while (rst && n < 20) begin
			@(negedge clk);
			n++;
			check_val("cpu_ack_o in reset", 32'(cpu_ack), 32'd0);
			check_val("bus cyc in reset", 32'(bus_req.cyc), 32'd0);
		end
		if (rst)
			report_failure("reset was never released");
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_val("cpu_ack_o after reset", 32'(cpu_ack), 32'd0);
			check_val("bus cyc after reset", 32'(bus_req.cyc), 32'd0);
		end
		end_test("reset", err0);

		// Stores over 4 words, bus order checked by the monitor
		err0 = errors;
		for (int i = 0; i < 24; i++)
			do_store(rand_addr(2), rand_bits(32), rand_sel());
		wait_drained();
		end_test("in-order drain", err0);

		// Loads right behind stores to the same words
		err0 = errors;
		for (int i = 0; i < 12; i++) begin
			n = 1 + int'(rand_bits(2));
			for (int k = 0; k < n; k++)
				do_store(rand_addr(2), rand_bits(32), rand_sel());
			do_load(rand_addr(2));
		end
		end_test("load ordering", err0);

		// Slow memory fills the FIFO
		err0 = errors;
		slow = 1'b1;
		for (int i = 0; i < 3 * `SB_ENTRIES; i++)
			do_store(rand_addr(4), rand_bits(32), rand_sel());
		wait_drained();
		slow = 1'b0;
		compare_memory();
		end_test("back-pressure", err0);

		// Random mix over the whole window
		err0 = errors;
		for (int i = 0; i < 300; i++) begin
			r = rand_bits(1);
			if (r[0])
				do_load(rand_addr(4));
			else
				do_store(rand_addr(4), rand_bits(32), rand_sel());
		end
		wait_drained();
		compare_memory();
		end_test("mixed traffic", err0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sb_tb_mem.sv
`timescale 1ns/1ps

module sb_tb_mem #(
	parameter logic [31:0] BASE = 32'h0000_1000	// Start of the 16 word window
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                slow_i,	// Long ack delays
	input  sb_pkg::sb_bus_req_t bus_req_i,
	output logic                bus_ack_o,
	output logic [31:0]         bus_rdat_o,
	output logic                wr_stb_o,	// One cycle per applied write
	output sb_pkg::sb_entry_t   wr_ent_o	// The write just applied
);

	logic [31:0] mem [16];
	logic [31:0] lfsr_q;
	int          wait_cnt;
	logic        active;	// Current bus cycle already seen

	// Same fill rule as the reference model
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a ^ 32'h5a5a_a5a5) + {a[15:0], a[31:16]};
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial begin
		bus_ack_o = 1'b0;
		bus_rdat_o = '0;
		wr_stb_o = 1'b0;
		wr_ent_o = '0;
		active = 1'b0;
		wait_cnt = 0;
		lfsr_q = 32'h7a78_0db5;
		for (int i = 0; i < 16; i++)
			mem[i] = fill_word(BASE + 32'(i) * 32'd4);
	end

	always @(negedge clk_i) begin : bus_side
		logic [31:0] word;
		logic [3:0]  idx;
		logic [2:0]  dly;
		if (rst_i) begin
			bus_ack_o = 1'b0;
			wr_stb_o = 1'b0;
			active = 1'b0;
		end else begin
			wr_stb_o = 1'b0;
			if (bus_ack_o) begin
				bus_ack_o = 1'b0;	// Ack is a single cycle
				active = 1'b0;
			end else if (bus_req_i.cyc) begin
				if (!active) begin
					active = 1'b1;
					for (int i = 0; i < 3; i++) begin	// One step per delay bit
						lfsr_q = lfsr_next(lfsr_q);
						dly[i] = lfsr_q[0];
					end
					wait_cnt = int'(dly) + (slow_i ? 16 : 0);
				end
				if (wait_cnt == 0) begin
					idx = bus_req_i.addr[5:2];
					word = mem[idx];
					if (bus_req_i.we) begin
						for (int b = 0; b < 4; b++)
							if (bus_req_i.sel[b])
								word[b*8 +: 8] = bus_req_i.data[b*8 +: 8];
						mem[idx] = word;
						wr_stb_o = 1'b1;
						wr_ent_o.addr = bus_req_i.addr;
						wr_ent_o.data = bus_req_i.data;
						wr_ent_o.sel = bus_req_i.sel;
					end
					bus_rdat_o = word;	// Reads see the whole word
					bus_ack_o = 1'b1;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

endmodule

// File: sb_top.f
+incdir+.
sb_pkg.sv
sb_fifo.sv
sb_drain.sv
sb_ctrl.sv
sb_top.sv
tb_clkgen.sv
sb_tb_mem.sv
sb_tb.sv

// File: sb_top.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_top (
	input  logic                clk_i,
	input  logic                rst_i,
	input  sb_pkg::sb_cpu_req_t cpu_req_i,	// CPU data port
	output logic                cpu_ack_o,
	output logic [31:0]         cpu_rdat_o,
	output sb_pkg::sb_bus_req_t bus_req_o,	// Memory bus
	input  logic                bus_ack_i,
	input  logic [31:0]         bus_rdat_i
);

	logic                fifo_wr;
	logic                fifo_rd;
	logic                fifo_full;
	logic                fifo_empty;
	sb_pkg::sb_entry_t   fifo_din;	// From controller
	sb_pkg::sb_entry_t   fifo_dout;	// Head, to drain
	sb_pkg::sb_bus_req_t drain_req;
	logic                drain_ack;
	logic                drain_busy;

	// Store queue
	sb_fifo #(
		.T       (sb_pkg::sb_entry_t),
		.LOG     (`SB_LOG),
		.ENTRIES (`SB_ENTRIES)
	) u_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.dat_i   (fifo_din),
		.wr_i    (fifo_wr),
		.rd_i    (fifo_rd),
		.dat_o   (fifo_dout),
		.full_o  (fifo_full),
		.empty_o (fifo_empty)
	);

	// Writes queued stores to the bus in order
	sb_drain u_drain (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.fifo_empty_i (fifo_empty),
		.fifo_dat_i   (fifo_dout),
		.fifo_rd_o    (fifo_rd),
		.wr_req_o     (drain_req),
		.wr_ack_i     (drain_ack),
		.busy_o       (drain_busy)
	);

	sb_ctrl u_ctrl (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cpu_req_i    (cpu_req_i),
		.cpu_ack_o    (cpu_ack_o),
		.cpu_rdat_o   (cpu_rdat_o),
		.fifo_wr_o    (fifo_wr),
		.fifo_dat_o   (fifo_din),
		.fifo_full_i  (fifo_full),
		.fifo_empty_i (fifo_empty),
		.drain_busy_i (drain_busy),
		.drain_req_i  (drain_req),
		.drain_ack_o  (drain_ack),
		.bus_req_o    (bus_req_o),
		.bus_ack_i    (bus_ack_i),
		.bus_rdat_i   (bus_rdat_i)
	);

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_NS = 50,	// 100 ns period
	parameter int RST_CYCLES = 4
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	// Reset released on a falling edge, after RST_CYCLES rising edges
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule
